/* vlog.f */
src/i2c_mon_pkg.sv
src/i2c_mon_regs.sv
src/i2c_bus_monitor.sv
src/i2c_mon_top.sv
dv/tb_i2c_mon.sv

/* Makefile */
# Verilator simulation of the I2C bus monitor
TOP := tb_i2c_mon

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench, fails on any error"
	@echo "  clean  remove build output"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f vlog.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* dv/tb_i2c_mon.sv */
/*
 * Testbench for the I2C bus monitor
 *  - Clock, reset, register and bus stimulus tasks
 *  - Model of the sticky status bits and the interrupt
 *  - Compare tasks and a watchdog
 */
module tb_i2c_mon;
  timeunit 1ns;
  timeprecision 100ps;
  import i2c_mon_pkg::*;

  localparam int Rounds     = 4;
  localparam int MaxThd     = 20;
  localparam int MaxTBuf    = 60;
  localparam int MaxActTo   = 80;
  localparam int MaxInactTo = 80;
  // Worst case cycles of all sequences, doubled for the watchdog
  localparam int SeqCycles  = 16 + Rounds * (20 * (MaxThd + 20) + MaxTBuf) +
                              8 * (MaxActTo + MaxInactTo + MaxTBuf + 4 * MaxThd) + 600;
  localparam int WdNs       = 2 * 4 * SeqCycles;

  logic              clk_i;
  logic              rst_ni;
  logic              scl_i;
  logic              sda_i;
  logic              target_idle_i;
  logic              we_i;
  reg_addr_e         addr_i;
  logic [REG_DW-1:0] wdata_i;
  logic [REG_DW-1:0] rdata_o;
  logic              irq_o;
  logic              bus_free_o;

  // Model state
  logic exp_start;
  logic exp_stop;
  logic exp_act;
  logic exp_host;
  logic mon_on;
  int   thd;
  int   tbuf;
  int   act_to;
  int   inact_to;

  i2c_mon_top i2c_mon_top_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .scl_i         (scl_i),
    .sda_i         (sda_i),
    .target_idle_i (target_idle_i),
    .we_i          (we_i),
    .addr_i        (addr_i),
    .wdata_i       (wdata_i),
    .rdata_o       (rdata_o),
    .irq_o         (irq_o),
    .bus_free_o    (bus_free_o)
  );

  always #2 clk_i = ~clk_i;

  task automatic check_word(input string name, input logic [REG_DW-1:0] act,
                            input logic [REG_DW-1:0] exp);
    if (act !== exp) begin
      $display("** Error: %s is 0x%0h, expected 0x%0h", name, act, exp);
      $display("Done: errors found");
      $fatal(1, "register mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      $display("** Error: %s is 0x%0h, expected 0x%0h", name, act, exp);
      $display("Done: errors found");
      $fatal(1, "bit mismatch");
    end
  endtask

  // Every drive lands 1 ns after a rising edge
  task automatic step(input int n);
    repeat (n) @(posedge clk_i);
    #1;
  endtask

  task automatic drive_bus(input logic scl, input logic sda, input int n);
    scl_i = scl;
    sda_i = sda;
    step(n);
  endtask

  task automatic write_reg(input reg_addr_e a, input logic [REG_DW-1:0] d);
    we_i    = 1'b1;
    addr_i  = a;
    wdata_i = d;
    step(1);
    we_i    = 1'b0;
    wdata_i = '0;
  endtask

  // Reads are combinational, so sample in the middle of the cycle
  task automatic read_check(input reg_addr_e a, input logic [REG_DW-1:0] exp);
    addr_i = a;
    #1;
    check_word(a.name(), rdata_o, exp);
    step(1);
  endtask

  function automatic logic [REG_DW-1:0] field_mask(input reg_addr_e a);
    case (a)
      RegCtrl:       return REG_DW'(4'hf);
      RegThdDat:     return {REG_DW{1'b1}} >> (REG_DW - THD_DAT_W);
      RegTBuf:       return {REG_DW{1'b1}} >> (REG_DW - T_BUF_W);
      RegActiveTo:   return {REG_DW{1'b1}} >> (REG_DW - ACTIVE_TO_W);
      RegInactiveTo: return {REG_DW{1'b1}} >> (REG_DW - INACTIVE_TO_W);
      default:       return '0;
    endcase
  endfunction

  // Bus free is live, so only the sticky bits are compared here
  task automatic check_status();
    logic [REG_DW-1:0] exp;
    exp               = '0;
    exp[StatStart]    = exp_start;
    exp[StatStop]     = exp_stop;
    exp[StatActiveTo] = exp_act;
    exp[StatHostTo]   = exp_host;
    addr_i = RegStatus;
    #1;
    check_word("status", rdata_o & ~REG_DW'(1), exp);
    check_bit("irq_o", irq_o, exp_start | exp_stop | exp_act | exp_host);
    step(1);
  endtask

  task automatic clear_status(input logic [REG_DW-1:0] m);
    write_reg(RegStatus, m);
    if (m[StatStart]) exp_start = 1'b0;
    if (m[StatStop]) exp_stop = 1'b0;
    if (m[StatActiveTo]) exp_act = 1'b0;
    if (m[StatHostTo]) exp_host = 1'b0;
    // irq_o trails the status bits by one cycle
    step(2);
  endtask

  task automatic wait_free(input int limit);
    int n;
    n = 0;
    while (!bus_free_o) begin
      if (n > limit) begin
        $display("bus_free_o did not return high within %0d cycles", limit);
        $display("Done: errors found");
        $fatal(1, "bus free timeout");
      end
      n++;
      step(1);
    end
  endtask

  // Holds stay clear of thd_dat so the outcome is never ambiguous
  function automatic int pick_hold(input bit long_hold);
    if (long_hold) return thd + 6 + int'($urandom % 8);
    return 1 + int'($urandom % (thd - 3));
  endfunction

  task automatic start_cond(input int hold);
    drive_bus(1'b0, 1'b1, 2);
    drive_bus(1'b1, 1'b1, 4);
    drive_bus(1'b1, 1'b0, hold);
    drive_bus(1'b0, 1'b0, 3);
    if (mon_on && hold >= thd + 6) exp_start = 1'b1;
  endtask

  task automatic stop_cond(input int hold);
    drive_bus(1'b0, 1'b0, 2);
    drive_bus(1'b1, 1'b0, 3);
    drive_bus(1'b1, 1'b1, hold);
    if (hold < thd + 6) begin
      // A glitch ends with SCL low before the Stop can qualify
      drive_bus(1'b0, 1'b1, 3);
    end else if (mon_on) begin
      exp_stop = 1'b1;
      check_bit("bus_free_o", bus_free_o, 1'b0);
      wait_free(tbuf + 6);
    end
  endtask

  // SDA only changes while SCL is low, bus stays free in single mode
  task automatic data_bit(input logic b);
    drive_bus(1'b0, b, 2);
    drive_bus(1'b1, b, 3);
    drive_bus(1'b0, b, 2);
    check_bit("bus_free_o", bus_free_o, 1'b1);
  endtask

  task automatic transfer(input bit long_hold, input int nbits);
    start_cond(pick_hold(long_hold));
    repeat (nbits) data_bit(1'($urandom));
    stop_cond(pick_hold(long_hold));
  endtask

  initial begin
    #(WdNs);
    $display("Watchdog expired after %0d ns, the run hung", WdNs);
    $display("Done: errors found");
    $fatal(1, "watchdog");
  end

  initial begin
    reg_addr_e         cfg [4];
    logic [REG_DW-1:0] d;
    cfg = '{RegThdDat, RegTBuf, RegActiveTo, RegInactiveTo};
    void'($urandom(74));
    clk_i = 1'b0;
    rst_ni = 1'b0;
    scl_i = 1'b1;
    sda_i = 1'b1;
    target_idle_i = 1'b0;
    we_i = 1'b0;
    addr_i = RegCtrl;
    wdata_i = '0;
    {exp_start, exp_stop, exp_act, exp_host} = 4'b0;
    mon_on = 1'b0;
    repeat (16) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    step(1);

    // Register access
    check_bit("bus_free_o", bus_free_o, 1'b1);
    for (int i = 0; i < 5; i++) read_check(reg_addr_e'(i), '0);
    // STATUS shows the idle bus as free and no events
    read_check(RegStatus, REG_DW'(1) << StatBusFree);
    foreach (cfg[i]) begin
      d = REG_DW'($urandom);
      write_reg(cfg[i], d);
      read_check(cfg[i], d & field_mask(cfg[i]));
    end
    d = REG_DW'($urandom);
    write_reg(RegCtrl, d);
    read_check(RegCtrl, d & field_mask(RegCtrl));
    write_reg(RegCtrl, '0);
    clear_status(REG_DW'(32'h1e));
    check_status();

    // Timing setup, single controller with the host timeout off
    thd      = 8 + int'($urandom % 13);
    tbuf     = 20 + int'($urandom % 41);
    act_to   = 40 + int'($urandom % 41);
    inact_to = 50 + int'($urandom % 31);
    write_reg(RegThdDat, REG_DW'(thd));
    write_reg(RegTBuf, REG_DW'(tbuf));
    write_reg(RegActiveTo, REG_DW'(act_to));
    write_reg(RegInactiveTo, '0);
    write_reg(RegCtrl, REG_DW'(1) << CtrlHostEn);
    mon_on = 1'b1;

    // Start and Stop detection with bus free checks
    for (int r = 0; r < Rounds; r++) begin
      transfer(1'b1, 2 + int'($urandom % 6));
      check_status();
      transfer(1'b0, 2);
      check_status();
      clear_status(REG_DW'($urandom) & REG_DW'(32'h1e));
      check_status();
    end

    // Active timeout, long and short SCL low, then with the enable clear
    write_reg(RegCtrl, (REG_DW'(1) << CtrlHostEn) | (REG_DW'(1) << CtrlActiveToEn));
    start_cond(pick_hold(1'b1));
    drive_bus(1'b0, 1'b0, act_to + 8);
    exp_act = 1'b1;
    stop_cond(pick_hold(1'b1));
    check_status();
    clear_status(REG_DW'(32'h1e));
    start_cond(pick_hold(1'b1));
    drive_bus(1'b0, 1'b0, act_to - 10);
    stop_cond(pick_hold(1'b1));
    write_reg(RegCtrl, REG_DW'(1) << CtrlHostEn);
    start_cond(pick_hold(1'b1));
    drive_bus(1'b0, 1'b0, act_to + 8);
    stop_cond(pick_hold(1'b1));
    exp_act = 1'b0;
    check_status();
    clear_status(REG_DW'(32'h1e));

    // Host timeout, only counted while the target is not idle
    write_reg(RegInactiveTo, REG_DW'(inact_to));
    for (int k = 0; k < 2; k++) begin
      target_idle_i = k[0];
      start_cond(pick_hold(1'b1));
      data_bit(1'b1);
      drive_bus(1'b1, 1'b1, inact_to + 8);
      if (!target_idle_i) exp_host = 1'b1;
      check_status();
      clear_status(REG_DW'(32'h1e));
    end

    // Multi-controller mode holds bus free low until the bus has idled
    target_idle_i = 1'b1;
    write_reg(RegCtrl, '0);
    write_reg(RegCtrl, (REG_DW'(1) << CtrlHostEn) | (REG_DW'(1) << CtrlMultiEn));
    step(2);
    check_bit("bus_free_o", bus_free_o, 1'b0);
    // Still busy a few cycles before the inactive timeout runs out
    step(inact_to - 8);
    check_bit("bus_free_o", bus_free_o, 1'b0);
    wait_free(12);
    check_status();

    // Disable in the middle of the bus free time, then traffic must set nothing
    write_reg(RegCtrl, '0);
    write_reg(RegCtrl, REG_DW'(1) << CtrlHostEn);
    target_idle_i = 1'b0;
    start_cond(pick_hold(1'b1));
    drive_bus(1'b0, 1'b0, 2);
    drive_bus(1'b1, 1'b0, 3);
    drive_bus(1'b1, 1'b1, thd + 6);
    check_bit("bus_free_o", bus_free_o, 1'b0);
    write_reg(RegCtrl, '0);
    mon_on = 1'b0;
    wait_free(3);
    clear_status(REG_DW'(32'h1e));
    transfer(1'b1, 4);
    drive_bus(1'b0, 1'b0, act_to + 8);
    drive_bus(1'b1, 1'b1, inact_to + 8);
    check_status();

    $display("Done: no errors");
    $finish;
  end

endmodule

/* src/i2c_mon_top.sv */
/*
 * Top level of the I2C bus monitor
 *  - Register block u_regs
 *  - Bus monitor u_bus_monitor
 */
module i2c_mon_top (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           scl_i,
  input  logic                           sda_i,
  input  logic                           target_idle_i,
  input  logic                           we_i,
  input  i2c_mon_pkg::reg_addr_e         addr_i,
  input  logic [i2c_mon_pkg::REG_DW-1:0] wdata_i,
  output logic [i2c_mon_pkg::REG_DW-1:0] rdata_o,
  output logic                           irq_o,
  output logic                           bus_free_o
);
  import i2c_mon_pkg::*;

  // Configuration levels from the register block
  logic                     ctrl_host_en;
  logic                     ctrl_multi_en;
  logic                     ctrl_target_en;
  logic                     ctrl_active_to_en;
  logic [THD_DAT_W-1:0]     thd_dat;
  logic [T_BUF_W-1:0]       t_buf;
  logic [ACTIVE_TO_W-1:0]   active_to;
  logic [INACTIVE_TO_W-1:0] inactive_to;
  // Event pulses from the monitor
  logic start_det;
  logic stop_det;
  logic active_to_evt;
  logic host_to_evt;

  i2c_mon_regs u_regs (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .we_i                (we_i),
    .addr_i              (addr_i),
    .wdata_i             (wdata_i),
    .start_det_i         (start_det),
    .stop_det_i          (stop_det),
    .active_to_evt_i     (active_to_evt),
    .host_to_evt_i       (host_to_evt),
    .bus_free_i          (bus_free_o),
    .rdata_o             (rdata_o),
    .irq_o               (irq_o),
    .ctrl_host_en_o      (ctrl_host_en),
    .ctrl_multi_en_o     (ctrl_multi_en),
    .ctrl_target_en_o    (ctrl_target_en),
    .ctrl_active_to_en_o (ctrl_active_to_en),
    .thd_dat_o           (thd_dat),
    .t_buf_o             (t_buf),
    .active_to_o         (active_to),
    .inactive_to_o       (inactive_to)
  );

  i2c_bus_monitor u_bus_monitor (
    .clk_i                      (clk_i),
    .rst_ni                     (rst_ni),
    .scl_i                      (scl_i),
    .sda_i                      (sda_i),
    .controller_enable_i        (ctrl_host_en),
    .multi_controller_enable_i  (ctrl_multi_en),
    .target_enable_i            (ctrl_target_en),
    .target_idle_i              (target_idle_i),
    .thd_dat_i                  (thd_dat),
    .t_buf_i                    (t_buf),
    .bus_active_timeout_i       (active_to),
    .bus_active_timeout_en_i    (ctrl_active_to_en),
    .bus_inactive_timeout_i     (inactive_to),
    .bus_free_o                 (bus_free_o),
    .start_detect_o             (start_det),
    .stop_detect_o              (stop_det),
    .event_bus_active_timeout_o (active_to_evt),
    .event_host_timeout_o       (host_to_evt)
  );

endmodule

/* src/i2c_bus_monitor.sv */
/*
 * I2C bus monitor
 *  - Two-flop synchronizers on SCL and SDA
 *  - Start and Stop detection qualified by the data hold time
 *  - Release counter for bus free time and SCL low and high timeouts
 *  - Bus state FSM, bus free flag and timeout events
 *  - Assertions on the detectors and the FSM
 */
module i2c_bus_monitor (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  scl_i,
  input  logic                                  sda_i,
  input  logic                                  controller_enable_i,
  input  logic                                  multi_controller_enable_i,
  input  logic                                  target_enable_i,
  input  logic                                  target_idle_i,
  input  logic [i2c_mon_pkg::THD_DAT_W-1:0]     thd_dat_i,
  input  logic [i2c_mon_pkg::T_BUF_W-1:0]       t_buf_i,
  input  logic [i2c_mon_pkg::ACTIVE_TO_W-1:0]   bus_active_timeout_i,
  input  logic                                  bus_active_timeout_en_i,
  input  logic [i2c_mon_pkg::INACTIVE_TO_W-1:0] bus_inactive_timeout_i,
  output logic                                  bus_free_o,
  output logic                                  start_detect_o,
  output logic                                  stop_detect_o,
  output logic                                  event_bus_active_timeout_o,
  output logic                                  event_host_timeout_o
);
  import i2c_mon_pkg::*;

  logic monitor_enable;
  logic monitor_enable_q;
  logic enable_rise;
  logic [1:0] scl_sync_q;
  logic [1:0] sda_sync_q;
  logic scl_s;
  logic sda_s;
  logic scl_prev_q;
  logic sda_prev_q;

  // The monitor only runs while at least one role is enabled
  assign monitor_enable = controller_enable_i | target_enable_i | multi_controller_enable_i;
  assign enable_rise    = monitor_enable && !monitor_enable_q;

  // Synchronizers idle high like a released bus
  // The prev flops give the edge detectors their last sample
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_sync_q       <= 2'b11;
      sda_sync_q       <= 2'b11;
      scl_prev_q       <= 1'b1;
      sda_prev_q       <= 1'b1;
      monitor_enable_q <= 1'b0;
    end else begin
      scl_sync_q       <= {scl_sync_q[0], scl_i};
      sda_sync_q       <= {sda_sync_q[0], sda_i};
      scl_prev_q       <= scl_s;
      sda_prev_q       <= sda_s;
      monitor_enable_q <= monitor_enable;
    end
  end

  assign scl_s = scl_sync_q[1];
  assign sda_s = sda_sync_q[1];

  // Start and Stop detection
  // An SDA edge with SCL high only arms a trigger. It counts once SCL has stayed
  // high for thd_dat cycles, which rejects early SDA changes around data bits
  logic start_trig;
  logic stop_trig;
  logic start_pend_q;
  logic stop_pend_q;
  logic start_det;
  logic stop_det;
  logic hold_met;
  logic [THD_DAT_W:0] hold_cnt_q;

  assign start_trig = monitor_enable && scl_prev_q && scl_s && sda_prev_q && !sda_s;
  assign stop_trig  = monitor_enable && scl_prev_q && scl_s && !sda_prev_q && sda_s;
  assign hold_met   = (hold_cnt_q >= {1'b0, thd_dat_i});
  assign start_det  = monitor_enable && start_pend_q && hold_met;
  assign stop_det   = monitor_enable && stop_pend_q && hold_met;

  // One hold counter is shared, a new trigger restarts it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_cnt_q <= '0;
    end else if (start_trig || stop_trig) begin
      hold_cnt_q <= (THD_DAT_W+1)'(1);
    end else if (start_pend_q || stop_pend_q) begin
      hold_cnt_q <= hold_cnt_q + 1'b1;
    end
  end

  // SCL falling while pending drops the trigger, so no pulse appears
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      start_pend_q <= 1'b0;
      stop_pend_q  <= 1'b0;
    end else begin
      if (start_trig) begin
        start_pend_q <= 1'b1;
      end else if (!monitor_enable || !scl_s || start_det || stop_trig) begin
        start_pend_q <= 1'b0;
      end
      if (stop_trig) begin
        stop_pend_q <= 1'b1;
      end else if (!monitor_enable || !scl_s || stop_det || start_trig) begin
        stop_pend_q <= 1'b0;
      end
    end
  end

  assign start_detect_o = start_det;
  assign stop_detect_o  = stop_det;

  // Release counter and bus state
  logic bus_idling;
  logic inactive_to_en;
  logic cnt_load;
  logic cnt_dec;
  logic cnt_one;
  logic [ACTIVE_TO_W-1:0] cnt_sel;
  logic [ACTIVE_TO_W-1:0] release_cnt_q;
  logic inactive_to_det;
  logic active_to_det_d;
  logic active_to_det_q;
  bus_state_e state_d;
  bus_state_e state_q;

  // SCL high with SDA steady means nobody is driving the bus right now
  assign bus_idling     = scl_s && (sda_s == sda_prev_q);
  // A zero inactive timeout switches the host timeout off
  assign inactive_to_en = (bus_inactive_timeout_i != '0);
  assign cnt_one        = (release_cnt_q == ACTIVE_TO_W'(1));

  // In multi-controller mode the bus counts as busy on enable until
  // the inactive timeout shows that nobody else is using it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      release_cnt_q <= '0;
    end else if (enable_rise && multi_controller_enable_i) begin
      release_cnt_q <= ACTIVE_TO_W'(bus_inactive_timeout_i);
    end else if (cnt_load) begin
      release_cnt_q <= cnt_sel;
    end else if (cnt_dec && (release_cnt_q != '0)) begin
      release_cnt_q <= release_cnt_q - 1'b1;
    end
  end

  always_comb begin
    state_d         = state_q;
    cnt_load        = 1'b0;
    cnt_dec         = 1'b0;
    cnt_sel         = ACTIVE_TO_W'(t_buf_i);
    inactive_to_det = 1'b0;
    active_to_det_d = active_to_det_q;

    if (!monitor_enable) begin
      // Disabled monitor parks in StBusFree and raises no events
      state_d         = StBusFree;
      active_to_det_d = 1'b0;
    end else begin
      unique case (state_q)
        StBusFree: begin
          active_to_det_d = 1'b0;
          if (!scl_s || !sda_s) begin
            state_d  = StBusBusyLow;
            cnt_load = 1'b1;
            cnt_sel  = bus_active_timeout_i;
          end
        end
        StBusBusyLow: begin
          // Count only while SCL is actually held low
          cnt_dec = !scl_s;
          if (stop_det) begin
            state_d  = StBusBusyStop;
            cnt_load = 1'b1;
          end else if (bus_idling && inactive_to_en) begin
            state_d  = StBusBusyHigh;
            cnt_load = 1'b1;
            cnt_sel  = ACTIVE_TO_W'(bus_inactive_timeout_i);
          end else if (scl_s) begin
            cnt_load = 1'b1;
            cnt_sel  = bus_active_timeout_i;
            // SCL let go after an active timeout, treat the bus as abandoned
            if (active_to_det_q) begin
              state_d = StBusFree;
            end
          end else if (cnt_one) begin
            active_to_det_d = bus_active_timeout_en_i;
          end
        end
        StBusBusyHigh: begin
          cnt_dec = 1'b1;
          if (stop_det) begin
            state_d  = StBusBusyStop;
            cnt_load = 1'b1;
          end else if (!bus_idling) begin
            state_d  = StBusBusyLow;
            cnt_load = 1'b1;
            cnt_sel  = bus_active_timeout_i;
          end else if (cnt_one) begin
            inactive_to_det = inactive_to_en;
            // With SDA low a later SCL or SDA change moves us on instead
            if (sda_s) begin
              state_d = StBusFree;
            end
          end
        end
        StBusBusyStop: begin
          cnt_dec = 1'b1;
          if (!scl_s || !sda_s) begin
            state_d  = StBusBusyLow;
            cnt_load = 1'b1;
            cnt_sel  = bus_active_timeout_i;
          end else if (cnt_one) begin
            state_d = StBusFree;
          end
        end
        default: state_d = StBusFree;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q         <= StBusFree;
      active_to_det_q <= 1'b0;
    end else begin
      active_to_det_q <= active_to_det_d;
      if (enable_rise && multi_controller_enable_i) begin
        state_q <= StBusBusyHigh;
      end else begin
        state_q <= state_d;
      end
    end
  end

  // Single controller only waits out the bus free time after a Stop
  assign bus_free_o = multi_controller_enable_i ? (state_q == StBusFree) :
                                                  (state_q != StBusBusyStop);

  assign event_bus_active_timeout_o = active_to_det_d && !active_to_det_q;
  // An idle target is not waiting on anybody, so the host timeout stays quiet
  assign event_host_timeout_o       = !target_idle_i && inactive_to_det;

  // The pending flags exclude each other, so the two symbols never coincide
  a_start_stop_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(start_detect_o && stop_detect_o));

  a_quiet_when_off: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !monitor_enable |-> !(start_detect_o || stop_detect_o ||
                          event_bus_active_timeout_o || event_host_timeout_o));

  a_free_after_off: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !monitor_enable |=> (state_q == StBusFree));

endmodule

/* src/i2c_mon_regs.sv */
/*
 * Register block for the I2C bus monitor
 *  - CTRL enables and the four timing registers
 *  - STATUS with live bus free and sticky write-1-to-clear events
 *  - Registered interrupt from the sticky events
 */
module i2c_mon_regs (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  we_i,
  input  i2c_mon_pkg::reg_addr_e                addr_i,
  input  logic [i2c_mon_pkg::REG_DW-1:0]        wdata_i,
  input  logic                                  start_det_i,
  input  logic                                  stop_det_i,
  input  logic                                  active_to_evt_i,
  input  logic                                  host_to_evt_i,
  input  logic                                  bus_free_i,
  output logic [i2c_mon_pkg::REG_DW-1:0]        rdata_o,
  output logic                                  irq_o,
  output logic                                  ctrl_host_en_o,
  output logic                                  ctrl_multi_en_o,
  output logic                                  ctrl_target_en_o,
  output logic                                  ctrl_active_to_en_o,
  output logic [i2c_mon_pkg::THD_DAT_W-1:0]     thd_dat_o,
  output logic [i2c_mon_pkg::T_BUF_W-1:0]       t_buf_o,
  output logic [i2c_mon_pkg::ACTIVE_TO_W-1:0]   active_to_o,
  output logic [i2c_mon_pkg::INACTIVE_TO_W-1:0] inactive_to_o
);
  import i2c_mon_pkg::*;

  logic status_wr;
  logic evt_start_q;
  logic evt_stop_q;
  logic evt_active_to_q;
  logic evt_host_to_q;

  // Configuration registers, each field keeps only its package width
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctrl_host_en_o      <= 1'b0;
      ctrl_multi_en_o     <= 1'b0;
      ctrl_target_en_o    <= 1'b0;
      ctrl_active_to_en_o <= 1'b0;
      thd_dat_o           <= '0;
      t_buf_o             <= '0;
      active_to_o         <= '0;
      inactive_to_o       <= '0;
    end else if (we_i) begin
      case (addr_i)
        RegCtrl: begin
          ctrl_host_en_o      <= wdata_i[CtrlHostEn];
          ctrl_multi_en_o     <= wdata_i[CtrlMultiEn];
          ctrl_target_en_o    <= wdata_i[CtrlTargetEn];
          ctrl_active_to_en_o <= wdata_i[CtrlActiveToEn];
        end
        RegThdDat:     thd_dat_o     <= wdata_i[THD_DAT_W-1:0];
        RegTBuf:       t_buf_o       <= wdata_i[T_BUF_W-1:0];
        RegActiveTo:   active_to_o   <= wdata_i[ACTIVE_TO_W-1:0];
        RegInactiveTo: inactive_to_o <= wdata_i[INACTIVE_TO_W-1:0];
        // STATUS writes are handled by the event logic below
        default: ;
      endcase
    end
  end

  assign status_wr = we_i && (addr_i == RegStatus);

  // Sticky events
  // A pulse in the same cycle as its clear keeps the bit set
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      evt_start_q     <= 1'b0;
      evt_stop_q      <= 1'b0;
      evt_active_to_q <= 1'b0;
      evt_host_to_q   <= 1'b0;
    end else begin
      evt_start_q     <= start_det_i |
                         (evt_start_q & ~(status_wr & wdata_i[StatStart]));
      evt_stop_q      <= stop_det_i |
                         (evt_stop_q & ~(status_wr & wdata_i[StatStop]));
      evt_active_to_q <= active_to_evt_i |
                         (evt_active_to_q & ~(status_wr & wdata_i[StatActiveTo]));
      evt_host_to_q   <= host_to_evt_i |
                         (evt_host_to_q & ~(status_wr & wdata_i[StatHostTo]));
    end
  end

  // Interrupt follows the sticky bits one cycle later
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      irq_o <= 1'b0;
    end else begin
      irq_o <= evt_start_q | evt_stop_q | evt_active_to_q | evt_host_to_q;
    end
  end

  // Read mux, unmapped addresses return zero
  always_comb begin
    rdata_o = '0;
    case (addr_i)
      RegCtrl: begin
        rdata_o[CtrlHostEn]     = ctrl_host_en_o;
        rdata_o[CtrlMultiEn]    = ctrl_multi_en_o;
        rdata_o[CtrlTargetEn]   = ctrl_target_en_o;
        rdata_o[CtrlActiveToEn] = ctrl_active_to_en_o;
      end
      RegThdDat:     rdata_o = REG_DW'(thd_dat_o);
      RegTBuf:       rdata_o = REG_DW'(t_buf_o);
      RegActiveTo:   rdata_o = REG_DW'(active_to_o);
      RegInactiveTo: rdata_o = REG_DW'(inactive_to_o);
      RegStatus: begin
        rdata_o[StatBusFree]  = bus_free_i;
        rdata_o[StatStart]    = evt_start_q;
        rdata_o[StatStop]     = evt_stop_q;
        rdata_o[StatActiveTo] = evt_active_to_q;
        rdata_o[StatHostTo]   = evt_host_to_q;
      end
      default: rdata_o = '0;
    endcase
  end

endmodule

/* src/i2c_mon_pkg.sv */
/*
 * Shared definitions for the I2C bus monitor
 *  - Field widths of the timing registers and the register data width
 *  - Register address map and CTRL and STATUS bit positions
 *  - Bus state encoding used by the monitor FSM
 */
package i2c_mon_pkg;

  // Timing field widths, sized for the slowest bus at the fastest clock
  localparam int unsigned THD_DAT_W     = 13;
  localparam int unsigned T_BUF_W       = 13;
  // The SCL-low timeout is the widest count, so it also sizes the release counter
  localparam int unsigned ACTIVE_TO_W   = 30;
  localparam int unsigned INACTIVE_TO_W = 20;
  localparam int unsigned REG_DW        = 32;

  // Register map
  typedef enum logic [2:0] {
    RegCtrl       = 3'd0,
    RegThdDat     = 3'd1,
    RegTBuf       = 3'd2,
    RegActiveTo   = 3'd3,
    RegInactiveTo = 3'd4,
    RegStatus     = 3'd5
  } reg_addr_e;

  // CTRL bit positions
  localparam int unsigned CtrlHostEn     = 0;
  localparam int unsigned CtrlMultiEn    = 1;
  localparam int unsigned CtrlTargetEn   = 2;
  localparam int unsigned CtrlActiveToEn = 3;

  // STATUS bit positions, bus free is live and the rest are sticky
  localparam int unsigned StatBusFree  = 0;
  localparam int unsigned StatStart    = 1;
  localparam int unsigned StatStop     = 2;
  localparam int unsigned StatActiveTo = 3;
  localparam int unsigned StatHostTo   = 4;

  // Bus state as seen by the monitor
  typedef enum logic [1:0] {
    // Nobody owns the bus
    StBusFree     = 2'd0,
    // Bus busy and SCL not held high
    StBusBusyLow  = 2'd1,
    // Bus busy with SCL held high, counting towards the host timeout
    StBusBusyHigh = 2'd2,
    // Stop seen, counting down the bus free time
    StBusBusyStop = 2'd3
  } bus_state_e;

endpackage
